/* cache_pkg.sv */
/* Shared widths and message layouts for the 2-way, 8-set L1 datapath.
   Length fields are not carried; line size is fixed at 16 bytes. */
`default_nettype none

package cache_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_OFF_W     = 2;
  localparam int NUM_SETS       = 8;
  localparam int IDX_W          = 3;
  localparam int LINE_ADDR_W    = 28;
  localparam int OPQ_W          = 8;

  typedef enum logic [2:0] {
    TYPE_READ    = 3'd0,
    TYPE_WRITE   = 3'd1,
    TYPE_INIT    = 3'd2,
    TYPE_AMO_ADD = 3'd3,
    TYPE_AMO_AND = 3'd4,
    TYPE_AMO_OR  = 3'd5
  } mem_type_t;

  typedef enum logic [1:0] {
    AMO_PASS = 2'd0,
    AMO_ADD  = 2'd1,
    AMO_AND  = 2'd2,
    AMO_OR   = 2'd3
  } amo_op_t;

  // ==================================================
  // Messages
  // ==================================================
  typedef struct packed {
    mem_type_t           msg_type;
    logic [OPQ_W-1:0]    opaque;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } mem_req_t;

  typedef struct packed {
    mem_type_t           msg_type;
    logic [OPQ_W-1:0]    opaque;
    logic [DATA_W-1:0]   data;
  } mem_resp_t;

  typedef struct packed {
    mem_type_t           msg_type;
    logic [OPQ_W-1:0]    opaque;
    logic [ADDR_W-1:0]   addr;
    logic [LINE_W-1:0]   data;
  } line_req_t;

  typedef struct packed {
    mem_type_t           msg_type;
    logic [OPQ_W-1:0]    opaque;
    logic [LINE_W-1:0]   data;
  } line_resp_t;

  // Registered request, address already split
  typedef struct packed {
    mem_type_t              msg_type;
    logic [OPQ_W-1:0]       opaque;
    logic [DATA_W-1:0]      data;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [WORD_OFF_W-1:0]  word_off;
    logic                   domain;
  } req_fields_t;

  // ==================================================
  // Controller interface
  // ==================================================
  typedef struct packed {
    amo_op_t             amo_sel;
    logic                cachereq_en;
    logic                memresp_en;
    logic                is_refill;
    logic [1:0]          tag_wen;
    logic [1:0]          nsb_wen;
    logic                way_sel;
    logic                data_array_wen;
    logic [LINE_W/8-1:0] data_array_wben;
    logic                read_data_reg_en;
    logic                read_tag_reg_en;
    mem_type_t           memreq_type;
    logic                secure_mask;
  } dpath_ctrl_t;

  typedef struct packed {
    mem_type_t           cachereq_type;
    logic [ADDR_W-1:0]   cachereq_addr;
    logic                cachereq_nsbit;
    logic [1:0]          tag_match;
    logic [1:0]          nsb_match;
  } dpath_status_t;

endpackage

`default_nettype wire

/* cache_req_decode.sv */
/* Captures one cache request per enable strobe.
   The byte-in-word offset is dropped; the index is the low bits of the line address. */
`timescale 1ns/1ps
`default_nettype none

module cache_req_decode
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         en,
  input  mem_req_t    cachereq_msg,
  input  wire         cachereq_domain,
  output req_fields_t fields
);

  logic [LINE_ADDR_W-1:0] line_addr_in;
  logic [WORD_OFF_W-1:0]  word_off_in;

  // Line address sits above the 16-byte offset
  assign line_addr_in = cachereq_msg.addr[ADDR_W-1 -: LINE_ADDR_W];
  assign word_off_in  = cachereq_msg.addr[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      fields <= '0;
    end else if (en) begin
      fields.msg_type  <= cachereq_msg.msg_type;
      fields.opaque    <= cachereq_msg.opaque;
      fields.data      <= cachereq_msg.data;
      fields.line_addr <= line_addr_in;
      fields.word_off  <= word_off_in;
      fields.domain    <= cachereq_domain;
    end
  end

endmodule

`default_nettype wire

/* cache_tag_way.sv */
/* One way of tag and NS-bit storage, read combinationally at the request index.
   Both arrays clear to zero on reset, so a zero line address hits after reset. */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_way
  import cache_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  input  req_fields_t            fields,
  input  wire                    tag_wen,
  input  wire                    nsb_wen,
  input  wire                    fill_domain,
  output logic                   tag_match,
  output logic                   nsb_match,
  output logic [LINE_ADDR_W-1:0] stored_line_addr
);

  logic [LINE_ADDR_W-1:0] tags [NUM_SETS];
  logic [NUM_SETS-1:0]    nsbs;
  logic [IDX_W-1:0]       idx;

  assign idx = fields.line_addr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_SETS; i++) begin
        tags[i] <= '0;
      end
      nsbs <= '0;
    end else begin
      if (tag_wen) begin
        tags[idx] <= fields.line_addr;
      end
      if (nsb_wen) begin
        nsbs[idx] <= fill_domain;
      end
    end
  end

  assign stored_line_addr = tags[idx];
  assign tag_match        = (tags[idx] == fields.line_addr);
  // Secure lines only for secure requests
  assign nsb_match        = (fields.domain >= nsbs[idx]);

endmodule

`default_nettype wire

/* cache_data_exec.sv */
/* Refill capture, store and atomic data, and the 16-entry line array.
   Entries are addressed as {index, way}; writes honour the per-byte enables. */
`timescale 1ns/1ps
`default_nettype none

module cache_data_exec
  import cache_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  dpath_ctrl_t       ctrl,
  input  req_fields_t       fields,
  input  line_resp_t        memresp_msg,
  input  wire               memresp_domain,
  output logic              fill_domain,
  input  wire  [DATA_W-1:0] resp_word,
  output logic [LINE_W-1:0] write_line,
  output logic [LINE_W-1:0] read_line
);

  localparam int ENTRIES = 2 * NUM_SETS;

  logic [LINE_W-1:0] memresp_line;
  logic [DATA_W-1:0] write_word;
  logic [LINE_W-1:0] fill_line;
  logic [IDX_W:0]    entry;
  logic [LINE_W-1:0] data_array [ENTRIES];

  // ==================================================
  // Memory response register
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      memresp_line <= '0;
      fill_domain  <= 1'b0;
    end else if (ctrl.memresp_en) begin
      memresp_line <= memresp_msg.data;
      fill_domain  <= memresp_domain;
    end
  end

  // Atomic result uses the word currently in the read register
  always_comb begin
    case (ctrl.amo_sel)
      AMO_ADD: write_word = fields.data + resp_word;
      AMO_AND: write_word = fields.data & resp_word;
      AMO_OR:  write_word = fields.data | resp_word;
      default: write_word = fields.data;
    endcase
  end

  // Same word in every slot, byte enables pick the target
  assign write_line = {WORDS_PER_LINE{write_word}};
  assign fill_line  = ctrl.is_refill ? memresp_line : write_line;
  assign entry      = {fields.line_addr[IDX_W-1:0], ctrl.way_sel};

  // ==================================================
  // Data array and read register
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        data_array[i] <= '0;
      end
    end else if (ctrl.data_array_wen) begin
      for (int b = 0; b < LINE_W / 8; b++) begin
        if (ctrl.data_array_wben[b]) begin
          data_array[entry][b*8 +: 8] <= fill_line[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_line <= '0;
    end else if (ctrl.read_data_reg_en) begin
      read_line <= data_array[entry];
    end
  end

endmodule

`default_nettype wire

/* cache_result.sv */
/* Response word select, secure masking and memory request assembly.
   Masked responses return zero data. Writeback address comes from the victim register. */
`timescale 1ns/1ps
`default_nettype none

module cache_result
  import cache_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  input  dpath_ctrl_t            ctrl,
  input  req_fields_t            fields,
  input  wire [LINE_W-1:0]       read_line,
  input  wire [LINE_W-1:0]       write_line,
  input  wire [LINE_ADDR_W-1:0]  way0_line_addr,
  input  wire [LINE_ADDR_W-1:0]  way1_line_addr,
  output logic [DATA_W-1:0]      resp_word,
  output mem_resp_t              cacheresp_msg,
  output logic                   cacheresp_domain,
  output line_req_t              memreq_msg,
  output logic                   memreq_domain
);

  logic [LINE_ADDR_W-1:0] victim_line_addr;
  logic [LINE_ADDR_W-1:0] memreq_line_addr;

  assign resp_word = read_line[fields.word_off*DATA_W +: DATA_W];

  // Victim line address, held for the writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_line_addr <= '0;
    end else if (ctrl.read_tag_reg_en) begin
      victim_line_addr <= ctrl.way_sel ? way1_line_addr : way0_line_addr;
    end
  end

  // ==================================================
  // Cache response
  // ==================================================
  assign cacheresp_msg.msg_type = fields.msg_type;
  assign cacheresp_msg.opaque   = fields.opaque;
  assign cacheresp_msg.data     = ctrl.secure_mask ? '0 : resp_word;
  assign cacheresp_domain       = fields.domain;

  // ==================================================
  // Memory request
  // ==================================================
  // Odd memreq types are writebacks
  assign memreq_line_addr    = ctrl.memreq_type[0] ? victim_line_addr : fields.line_addr;
  assign memreq_msg.msg_type = ctrl.memreq_type;
  assign memreq_msg.opaque   = '0;
  assign memreq_msg.addr     = {memreq_line_addr, 4'b0000};
  assign memreq_msg.data     = write_line;
  assign memreq_domain       = fields.domain;

endmodule

`default_nettype wire

/* cache_dpath.sv */
/* Blocking L1 datapath top: 2 ways, 8 sets, 16-byte lines, one NS bit per line.
   All sequencing is left to an outside controller driving the ctrl strobes. */
`timescale 1ns/1ps
`default_nettype none

module cache_dpath
  import cache_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  mem_req_t      cachereq_msg,
  input  wire           cachereq_domain,
  input  line_resp_t    memresp_msg,
  input  wire           memresp_domain,
  input  dpath_ctrl_t   ctrl,
  output mem_resp_t     cacheresp_msg,
  output logic          cacheresp_domain,
  output line_req_t     memreq_msg,
  output logic          memreq_domain,
  output dpath_status_t status
);

  req_fields_t            fields;
  logic                   fill_domain;
  logic [DATA_W-1:0]      resp_word;
  logic [LINE_W-1:0]      write_line;
  logic [LINE_W-1:0]      read_line;
  logic [1:0]             tag_match;
  logic [1:0]             nsb_match;
  logic [LINE_ADDR_W-1:0] way_line_addr [2];

  cache_req_decode u_decode (
    .clk             (clk),
    .rst             (rst),
    .en              (ctrl.cachereq_en),
    .cachereq_msg    (cachereq_msg),
    .cachereq_domain (cachereq_domain),
    .fields          (fields)
  );

  // One tag way per associativity slot
  for (genvar w = 0; w < 2; w++) begin : g_way
    cache_tag_way u_way (
      .clk              (clk),
      .rst              (rst),
      .fields           (fields),
      .tag_wen          (ctrl.tag_wen[w]),
      .nsb_wen          (ctrl.nsb_wen[w]),
      .fill_domain      (fill_domain),
      .tag_match        (tag_match[w]),
      .nsb_match        (nsb_match[w]),
      .stored_line_addr (way_line_addr[w])
    );
  end

  cache_data_exec u_exec (
    .clk            (clk),
    .rst            (rst),
    .ctrl           (ctrl),
    .fields         (fields),
    .memresp_msg    (memresp_msg),
    .memresp_domain (memresp_domain),
    .fill_domain    (fill_domain),
    .resp_word      (resp_word),
    .write_line     (write_line),
    .read_line      (read_line)
  );

  cache_result u_result (
    .clk              (clk),
    .rst              (rst),
    .ctrl             (ctrl),
    .fields           (fields),
    .read_line        (read_line),
    .write_line       (write_line),
    .way0_line_addr   (way_line_addr[0]),
    .way1_line_addr   (way_line_addr[1]),
    .resp_word        (resp_word),
    .cacheresp_msg    (cacheresp_msg),
    .cacheresp_domain (cacheresp_domain),
    .memreq_msg       (memreq_msg),
    .memreq_domain    (memreq_domain)
  );

  // Byte offset is not kept, so it reads back as zero
  assign status.cachereq_type  = fields.msg_type;
  assign status.cachereq_addr  = {fields.line_addr, fields.word_off, 2'b00};
  assign status.cachereq_nsbit = fields.domain;
  assign status.tag_match      = tag_match;
  assign status.nsb_match      = nsb_match;

endmodule

`default_nettype wire

/* cache_dpath_chk.sv */
/* Concurrent checks bound into every cache_dpath instance.
   Domain outputs follow the captured request; masking must clear response data. */
`timescale 1ns/1ps
`default_nettype none

module cache_dpath_chk
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  dpath_ctrl_t ctrl,
  input  wire         cachereq_domain,
  input  mem_resp_t   cacheresp_msg,
  input  wire         cacheresp_domain,
  input  wire         memreq_domain
);

  // Both domain outputs follow the captured request domain
  a_domain_equal: assert property (@(posedge clk) disable iff (rst)
    ctrl.cachereq_en |=> (cacheresp_domain == $past(cachereq_domain) &&
                          memreq_domain == $past(cachereq_domain)))
    else $error("domain outputs do not follow the captured request domain");

  a_reset_domain: assert property (@(posedge clk)
    rst |=> (!cacheresp_domain && !memreq_domain))
    else $error("domain outputs not cleared by reset");

  a_secure_mask: assert property (@(posedge clk) disable iff (rst)
    ctrl.secure_mask |-> (cacheresp_msg.data == '0))
    else $error("response data not masked while secure_mask is high");

endmodule

bind cache_dpath cache_dpath_chk chk0 (
  .clk              (clk),
  .rst              (rst),
  .ctrl             (ctrl),
  .cachereq_domain  (cachereq_domain),
  .cacheresp_msg    (cacheresp_msg),
  .cacheresp_domain (cacheresp_domain),
  .memreq_domain    (memreq_domain)
);

`default_nettype wire

/* tb_cache_dpath.sv */
/* Testbench for cache_dpath that plays the outside controller with one-cycle strobes.
   Every strobe and level is driven on the falling edge; outputs are compared at the rising edge. */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_dpath
  import cache_pkg::*;
();

  typedef enum int {
    CHK_DATA, CHK_TAG, CHK_NSB, CHK_MADDR, CHK_MDATA, CHK_MTYPE, CHK_OPQ,
    CHK_DOM, CHK_RTYPE, CHK_ADDR
  } chk_sel_t;

  logic          clk = 1'b0;
  logic          rst;
  mem_req_t      cachereq_msg;
  logic          cachereq_domain;
  line_resp_t    memresp_msg;
  logic          memresp_domain;
  dpath_ctrl_t   ctrl;
  dpath_ctrl_t   levels;
  mem_resp_t     cacheresp_msg;
  logic          cacheresp_domain;
  line_req_t     memreq_msg;
  logic          memreq_domain;
  dpath_status_t status;

  // Reference state, one line per {index, way}
  logic [LINE_W-1:0]      model_mem [16];
  logic [LINE_ADDR_W-1:0] model_tag [2][NUM_SETS];
  logic                   model_nsb [2][NUM_SETS];

  logic [LINE_ADDR_W-1:0] cur_la;
  logic [1:0]             cur_off;
  logic [DATA_W-1:0]      cur_data;
  logic [31:0]            seed = 32'hf563_a7b3;
  string                  chk_name;
  chk_sel_t               chk_sel;
  logic [LINE_W-1:0]      chk_exp;
  logic                   chk_on = 1'b0;
  int                     check_count = 0;
  int                     err_count = 0;
  int                     cycles = 0;

  cache_dpath dut0 (
    .clk              (clk),
    .rst              (rst),
    .cachereq_msg     (cachereq_msg),
    .cachereq_domain  (cachereq_domain),
    .memresp_msg      (memresp_msg),
    .memresp_domain   (memresp_domain),
    .ctrl             (ctrl),
    .cacheresp_msg    (cacheresp_msg),
    .cacheresp_domain (cacheresp_domain),
    .memreq_msg       (memreq_msg),
    .memreq_domain    (memreq_domain),
    .status           (status)
  );

  always #2 clk = ~clk;

  // ==================================================
  // Reference functions
  // ==================================================
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [DATA_W-1:0] amo_ref(input amo_op_t op, input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
    case (op)
      AMO_ADD: return a + b;
      AMO_AND: return a & b;
      AMO_OR:  return a | b;
      default: return a;
    endcase
  endfunction

  function automatic logic [LINE_W-1:0] model_line(input logic [2:0] idx, input logic way);
    return model_mem[{idx, way}];
  endfunction

  function automatic logic [DATA_W-1:0] model_word(input logic [2:0] idx, input logic way,
                                                   input logic [1:0] off);
    logic [LINE_W-1:0] line;
    line = model_line(idx, way);
    return line[off*32 +: 32];
  endfunction

  function automatic logic [1:0] exp_tag_match(input logic [LINE_ADDR_W-1:0] la);
    return {model_tag[1][la[2:0]] == la, model_tag[0][la[2:0]] == la};
  endfunction

  function automatic logic [1:0] exp_nsb_match(input logic [LINE_ADDR_W-1:0] la,
                                               input logic dom);
    return {dom >= model_nsb[1][la[2:0]], dom >= model_nsb[0][la[2:0]]};
  endfunction

  // ==================================================
  // Compare process and cycle limit
  // ==================================================
  always @(posedge clk) begin
    logic [LINE_W-1:0] act;
    if (chk_on) begin
      case (chk_sel)
        CHK_DATA:  act = 128'(cacheresp_msg.data);
        CHK_TAG:   act = 128'(status.tag_match);
        CHK_NSB:   act = 128'(status.nsb_match);
        CHK_MADDR: act = 128'(memreq_msg.addr);
        CHK_MDATA: act = memreq_msg.data;
        CHK_MTYPE: act = 128'({memreq_msg.opaque, memreq_msg.msg_type});
        CHK_OPQ:   act = 128'(cacheresp_msg.opaque);
        CHK_DOM:   act = 128'({cacheresp_domain, memreq_domain, status.cachereq_nsbit});
        CHK_RTYPE: act = 128'({cacheresp_msg.msg_type, status.cachereq_type});
        default:   act = 128'(status.cachereq_addr);
      endcase
      check_count++;
      assert (act === chk_exp) else begin
        err_count++;
        $display("error %s expected %h actual %h", chk_name, chk_exp, act);
      end
    end
  end

  // Limit covers about 5 tests of up to 60 strobes each with wide margin
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == 2000) begin
      $display("timeout: the test sequence did not finish within %0d cycles", cycles);
      $display("checks %0d errors %0d", check_count, err_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ==================================================
  // Controller tasks, all entered on a falling edge
  // ==================================================
  task automatic strobe(input dpath_ctrl_t c);
    ctrl = c;
    @(negedge clk);
    ctrl = levels;
  endtask

  task automatic set_levels(input dpath_ctrl_t c);
    levels = c;
    ctrl   = c;
  endtask

  task automatic check_output(input string name, input chk_sel_t sel,
                              input logic [LINE_W-1:0] exp);
    chk_name = name;
    chk_sel  = sel;
    chk_exp  = exp;
    chk_on   = 1'b1;
    @(negedge clk);
    chk_on = 1'b0;
  endtask

  task automatic send_req(input mem_type_t t, input logic [7:0] opq,
                          input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic dom);
    dpath_ctrl_t c;
    c = levels;
    c.cachereq_en = 1'b1;
    cachereq_msg.msg_type = t;
    cachereq_msg.opaque   = opq;
    cachereq_msg.addr     = addr;
    cachereq_msg.data     = data;
    cachereq_domain       = dom;
    cur_la   = addr[31:4];
    cur_off  = addr[3:2];
    cur_data = data;
    strobe(c);
  endtask

  task automatic refill_way(input logic way, input logic [LINE_W-1:0] line, input logic dom);
    dpath_ctrl_t c;
    memresp_msg.data = line;
    memresp_domain   = dom;
    c = levels;
    c.memresp_en = 1'b1;
    strobe(c);
    c = levels;
    c.tag_wen[way]    = 1'b1;
    c.nsb_wen[way]    = 1'b1;
    c.data_array_wen  = 1'b1;
    c.data_array_wben = '1;
    c.is_refill       = 1'b1;
    c.way_sel         = way;
    strobe(c);
    model_mem[{cur_la[2:0], way}] = line;
    model_tag[way][cur_la[2:0]]   = cur_la;
    model_nsb[way][cur_la[2:0]]   = dom;
  endtask

  task automatic read_entry(input logic way);
    dpath_ctrl_t c;
    c = levels;
    c.way_sel          = way;
    c.read_data_reg_en = 1'b1;
    strobe(c);
  endtask

  // For atomics the read register must already hold the old word
  task automatic write_entry(input logic way, input amo_op_t op);
    dpath_ctrl_t       c;
    logic [DATA_W-1:0] old_word;
    old_word = model_word(cur_la[2:0], way, cur_off);
    c = levels;
    c.amo_sel         = op;
    c.way_sel         = way;
    c.data_array_wen  = 1'b1;
    c.data_array_wben = 16'h000f << {cur_off, 2'b00};
    strobe(c);
    model_mem[{cur_la[2:0], way}][cur_off*32 +: 32] = amo_ref(op, cur_data, old_word);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    logic [LINE_ADDR_W-1:0] la;
    logic [LINE_ADDR_W-1:0] lb;
    logic [LINE_ADDR_W-1:0] lc;
    logic [LINE_W-1:0]      line;
    logic [DATA_W-1:0]      d;
    dpath_ctrl_t            c;
    rst = 1'b1;
    ctrl = '0;
    levels = '0;
    cachereq_msg = '0;
    cachereq_domain = 1'b0;
    memresp_msg = '0;
    memresp_domain = 1'b0;
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = '0;
      model_tag[i/8][i%8] = '0;
      model_nsb[i/8][i%8] = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Refill into way 0, then hit on every word offset
    seed = lcg(seed);
    la = seed[27:0] | 28'h800_0000;
    send_req(TYPE_READ, 8'h11, {la, 4'h0}, 32'h0, 1'b0);
    for (int k = 0; k < 4; k++) begin
      seed = lcg(seed);
      line[k*32 +: 32] = seed;
    end
    refill_way(1'b0, line, 1'b0);
    for (int k = 0; k < 4; k++) begin
      send_req(TYPE_READ, 8'h12, {la, 2'(k), 2'b00}, 32'h0, 1'b0);
      read_entry(1'b0);
      check_output("refill_hit data", CHK_DATA, 128'(model_word(la[2:0], 1'b0, 2'(k))));
    end
    check_output("refill_hit tag", CHK_TAG, 128'(exp_tag_match(la)));

    // Same set with another tag gives a miss and a refill read request
    lb = la ^ 28'h000_0010;
    send_req(TYPE_READ, 8'h21, {lb, 4'h0}, 32'h0, 1'b0);
    check_output("miss tag", CHK_TAG, 128'(exp_tag_match(lb)));
    check_output("miss status addr", CHK_ADDR, 128'({lb, 4'h0}));
    check_output("miss memreq addr", CHK_MADDR, 128'({lb, 4'h0}));
    check_output("miss memreq type", CHK_MTYPE, 128'({8'h00, TYPE_READ}));

    // Secure line in way 1
    seed = lcg(seed);
    lc = seed[27:0] | 28'h400_0000;
    send_req(TYPE_READ, 8'h31, {lc, 4'h4}, 32'h0, 1'b1);
    for (int k = 0; k < 4; k++) begin
      seed = lcg(seed);
      line[k*32 +: 32] = seed;
    end
    refill_way(1'b1, line, 1'b1);
    check_output("domain secure nsb", CHK_NSB, 128'(exp_nsb_match(lc, 1'b1)));
    check_output("domain secure outputs", CHK_DOM, 128'(3'b111));
    send_req(TYPE_READ, 8'h32, {lc, 4'h4}, 32'h0, 1'b0);
    check_output("domain insecure nsb", CHK_NSB, 128'(exp_nsb_match(lc, 1'b0)));
    check_output("domain insecure outputs", CHK_DOM, 128'(3'b000));
    read_entry(1'b1);
    check_output("domain data", CHK_DATA, 128'(model_word(lc[2:0], 1'b1, 2'd1)));
    c = '0;
    c.secure_mask = 1'b1;
    set_levels(c);
    check_output("domain masked data", CHK_DATA, 128'(0));
    set_levels('0);

    // Store, then add, and, or on one word of way 0
    seed = lcg(seed);
    send_req(TYPE_WRITE, 8'h41, {la, seed[1:0], 2'b00}, lcg(seed), 1'b0);
    write_entry(1'b0, AMO_PASS);
    read_entry(1'b0);
    check_output("store data", CHK_DATA, 128'(model_word(la[2:0], 1'b0, cur_off)));
    for (int n = 1; n < 4; n++) begin
      seed = lcg(seed);
      send_req(mem_type_t'(n + 2), 8'h41, {la, cur_off, 2'b00}, seed, 1'b0);
      read_entry(1'b0);
      write_entry(1'b0, amo_op_t'(n));
      read_entry(1'b0);
      check_output("amo data", CHK_DATA, 128'(model_word(la[2:0], 1'b0, cur_off)));
    end

    // Writeback of the way 0 victim in the shared set
    seed = lcg(seed);
    d = seed;
    send_req(TYPE_WRITE, 8'h5a, {lb, 4'h8}, d, 1'b0);
    c = levels;
    c.way_sel         = 1'b0;
    c.read_tag_reg_en = 1'b1;
    strobe(c);
    c = '0;
    c.memreq_type = TYPE_WRITE;
    set_levels(c);
    check_output("wb memreq addr", CHK_MADDR, 128'({model_tag[0][lb[2:0]], 4'h0}));
    check_output("wb memreq data", CHK_MDATA, {4{d}});
    check_output("wb memreq type", CHK_MTYPE, 128'({8'h00, TYPE_WRITE}));
    check_output("wb resp opaque", CHK_OPQ, 128'(8'h5a));
    check_output("wb resp type", CHK_RTYPE, 128'({TYPE_WRITE, TYPE_WRITE}));
    set_levels('0);
    check_output("wb request addr", CHK_MADDR, 128'({lb, 4'h0}));

    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
cache_pkg.sv
cache_req_decode.sv
cache_tag_way.sv
cache_data_exec.sv
cache_result.sv
cache_dpath.sv
cache_dpath_chk.sv
tb_cache_dpath.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cache_dpath
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell cat compile.f)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) compile.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f compile.f

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJDIR)
